//--- Makefile
VERILATOR ?= verilator
TOP ?= core_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int xlen = 32;
  localparam int cause_w = 4;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
  localparam logic [xlen-1:0] trap_vector = 32'h0000_0100;
  localparam logic [31:0] nop_instr = 32'h0000_0013;  // addi x0,x0,0

  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [cause_w-1:0] cause_illegal = 4'd2;
  localparam logic [cause_w-1:0] cause_breakpoint = 4'd3;
  localparam logic [cause_w-1:0] cause_misaligned_load = 4'd4;
  localparam logic [cause_w-1:0] cause_misaligned_store = 4'd6;
  localparam logic [cause_w-1:0] cause_ecall = 4'd11;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
  } alu_op_type;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_type;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } i_fmt_type;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_type;

  typedef struct packed {
    logic imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic imm11;
    logic [6:0] opcode;
  } b_fmt_type;

  typedef struct packed {
    logic imm20;
    logic [9:0] imm10_1;
    logic imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_type;

  // One word, five encodings
  typedef union packed {
    r_fmt_type r_fmt;
    i_fmt_type i_fmt;
    s_fmt_type s_fmt;
    b_fmt_type b_fmt;
    j_fmt_type j_fmt;
  } instr_word_union;

  typedef struct packed {
    alu_op_type alu_op;
    logic [xlen-1:0] imm;
    logic [4:0] waddr;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic wren;
    logic rden1;
    logic rden2;
    logic use_imm;
    logic lui;
    logic jal;
    logic jalr;
    logic branch;
    logic branch_ne;
    logic load;
    logic store;
    logic ecall;
    logic ebreak;
    logic valid;
  } ctrl_type;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    instr_word_union instr;
  } fetch_reg_type;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    alu_op_type alu_op;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] sdata;
    logic [xlen-1:0] addr;
    logic [4:0] waddr;
    logic wren;
    logic load;
    logic store;
  } decode_reg_type;

endpackage

`default_nettype wire

//--- hw/core_top.sv
`default_nettype none

module core_top
  import core_pkg::*;
(
  input wire logic clock,
  input wire logic reset,
  output logic [xlen-1:0] imem_addr,
  input wire logic [xlen-1:0] imem_data,
  output logic dmem_valid,
  output logic dmem_write,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  input wire logic [xlen-1:0] dmem_rdata,
  output logic trap,
  output logic [xlen-1:0] trap_pc,
  output logic [cause_w-1:0] trap_cause
);

  fetch_reg_type fetch;
  decode_reg_type decoded;
  logic redirect;
  logic [xlen-1:0] redirect_pc;
  logic [4:0] raddr1, raddr2;
  logic [xlen-1:0] rdata1, rdata2;
  logic wb_wen;
  logic [4:0] wb_waddr;
  logic [xlen-1:0] wb_wdata;

  fetch_stage u_fetch (
    .clock(clock),
    .reset(reset),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .fetch(fetch)
  );

  decode_stage u_decode (
    .clock(clock),
    .reset(reset),
    .fetch(fetch),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .forward_wen(wb_wen),
    .forward_waddr(wb_waddr),
    .forward_data(wb_wdata),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .trap(trap),
    .trap_pc(trap_pc),
    .trap_cause(trap_cause),
    .decoded(decoded)
  );

  register_file u_regs (
    .clock(clock),
    .reset(reset),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .wen(wb_wen),
    .waddr(wb_waddr),
    .wdata(wb_wdata)
  );

  execute_stage u_execute (
    .clock(clock),
    .reset(reset),
    .decoded(decoded),
    .dmem_valid(dmem_valid),
    .dmem_write(dmem_write),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .wen(wb_wen),
    .waddr(wb_waddr),
    .wdata(wb_wdata)
  );

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`default_nettype none

module decode_stage
  import core_pkg::*;
(
  input wire logic clock,
  input wire logic reset,
  input wire fetch_reg_type fetch,
  output logic [4:0] raddr1,
  output logic [4:0] raddr2,
  input wire logic [xlen-1:0] rdata1,
  input wire logic [xlen-1:0] rdata2,
  input wire logic forward_wen,
  input wire logic [4:0] forward_waddr,
  input wire logic [xlen-1:0] forward_data,
  output logic redirect,
  output logic [xlen-1:0] redirect_pc,
  output logic trap,
  output logic [xlen-1:0] trap_pc,
  output logic [cause_w-1:0] trap_cause,
  output decode_reg_type decoded
);

  ctrl_type ctrl;
  decode_reg_type next;
  logic [xlen-1:0] src1, src2, mem_addr, target;
  logic fwd1, fwd2, taken, misaligned, exception, link;
  logic [cause_w-1:0] cause;

  instr_decoder u_decoder (
    .instr(fetch.instr),
    .ctrl(ctrl)
  );

  assign raddr1 = ctrl.raddr1;
  assign raddr2 = ctrl.raddr2;

  // Result in execute wins over the register file
  assign fwd1 = ctrl.rden1 && forward_wen && ctrl.raddr1 != 5'd0 && forward_waddr == ctrl.raddr1;
  assign fwd2 = ctrl.rden2 && forward_wen && ctrl.raddr2 != 5'd0 && forward_waddr == ctrl.raddr2;
  assign src1 = fwd1 ? forward_data : rdata1;
  assign src2 = fwd2 ? forward_data : rdata2;

  assign mem_addr = src1 + ctrl.imm;
  assign link = ctrl.jal || ctrl.jalr;
  assign taken = link || (ctrl.branch && ((src1 == src2) != ctrl.branch_ne));
  assign target = ctrl.jalr ? {mem_addr[xlen-1:1], 1'b0} : fetch.pc + ctrl.imm;
  assign misaligned = (ctrl.load || ctrl.store) && mem_addr[1:0] != 2'b00;

  always_comb begin
    exception = 1'b1;
    if (!ctrl.valid) begin
      cause = cause_illegal;
    end else if (ctrl.ebreak) begin
      cause = cause_breakpoint;
    end else if (ctrl.ecall) begin
      cause = cause_ecall;
    end else if (misaligned && ctrl.load) begin
      cause = cause_misaligned_load;
    end else if (misaligned) begin
      cause = cause_misaligned_store;
    end else begin
      exception = 1'b0;
      cause = '0;
    end
  end

  assign trap = fetch.valid && exception;  // bubbles never trap
  assign trap_pc = fetch.pc;
  assign trap_cause = cause;
  assign redirect = fetch.valid && (exception || taken);
  assign redirect_pc = exception ? trap_vector : target;

  always_comb begin
    next.valid = fetch.valid && !exception;
    next.pc = fetch.pc;
    next.alu_op = ctrl.alu_op;
    next.op_a = link ? fetch.pc : src1;
    next.op_b = link ? 32'd4 : ((ctrl.use_imm || ctrl.lui) ? ctrl.imm : src2);
    next.sdata = src2;
    next.addr = mem_addr;
    next.waddr = ctrl.waddr;
    // Squashed slot leaves no side effects
    next.wren = next.valid && ctrl.wren;
    next.load = next.valid && ctrl.load;
    next.store = next.valid && ctrl.store;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      decoded.valid <= 1'b0;
      decoded.wren <= 1'b0;
      decoded.load <= 1'b0;
      decoded.store <= 1'b0;
    end else begin
      decoded <= next;
    end
  end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`default_nettype none

module execute_stage
  import core_pkg::*;
(
  input wire logic clock,
  input wire logic reset,
  input wire decode_reg_type decoded,
  output logic dmem_valid,
  output logic dmem_write,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  input wire logic [xlen-1:0] dmem_rdata,
  output logic wen,
  output logic [4:0] waddr,
  output logic [xlen-1:0] wdata
);

  logic [xlen-1:0] alu_result;
  logic less;

  assign less = $signed(decoded.op_a) < $signed(decoded.op_b);

  always_comb begin
    case (decoded.alu_op)
      alu_add: alu_result = decoded.op_a + decoded.op_b;
      alu_sub: alu_result = decoded.op_a - decoded.op_b;
      alu_and: alu_result = decoded.op_a & decoded.op_b;
      alu_or: alu_result = decoded.op_a | decoded.op_b;
      alu_xor: alu_result = decoded.op_a ^ decoded.op_b;
      alu_slt: alu_result = {{(xlen-1){1'b0}}, less};
      alu_pass_b: alu_result = decoded.op_b;  // lui
      default: alu_result = decoded.op_a + decoded.op_b;
    endcase
  end

  // Memory answers in this same cycle
  assign dmem_valid = decoded.valid && (decoded.load || decoded.store);
  assign dmem_write = decoded.valid && decoded.store;
  assign dmem_addr = decoded.addr;
  assign dmem_wdata = decoded.sdata;

  // Register file takes it at the next edge, decode sees it now
  assign wen = decoded.valid && decoded.wren;
  assign waddr = decoded.waddr;
  assign wdata = decoded.load ? dmem_rdata : alu_result;

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`default_nettype none

module fetch_stage
  import core_pkg::*;
(
  input wire logic clock,
  input wire logic reset,
  input wire logic redirect,
  input wire logic [xlen-1:0] redirect_pc,
  output logic [xlen-1:0] imem_addr,
  input wire logic [xlen-1:0] imem_data,
  output fetch_reg_type fetch
);

  logic [xlen-1:0] pc;

  assign imem_addr = pc;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc <= reset_pc;
      fetch.valid <= 1'b0;
      fetch.pc <= reset_pc;
      fetch.instr <= nop_instr;
    end else if (redirect) begin
      pc <= redirect_pc;
      // Word at pc is on the wrong path
      fetch.valid <= 1'b0;
      fetch.pc <= pc;
      fetch.instr <= nop_instr;
    end else begin
      pc <= pc + 32'd4;
      fetch.valid <= 1'b1;
      fetch.pc <= pc;
      fetch.instr <= imem_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`default_nettype none

module instr_decoder
  import core_pkg::*;
(
  input wire instr_word_union instr,
  output ctrl_type ctrl
);

  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

  assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                  instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
  assign imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                  instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
  // Upper bits 31:12 in their raw order
  assign imm_u = {instr.j_fmt.imm20, instr.j_fmt.imm10_1, instr.j_fmt.imm11,
                  instr.j_fmt.imm19_12, 12'h000};

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    ctrl.waddr = instr.r_fmt.rd;
    ctrl.raddr1 = instr.r_fmt.rs1;
    ctrl.raddr2 = instr.r_fmt.rs2;
    case (instr.r_fmt.opcode)
      op_lui: begin
        ctrl = '{alu_op: alu_pass_b, imm: imm_u, waddr: ctrl.waddr, raddr1: ctrl.raddr1,
                 raddr2: ctrl.raddr2, wren: 1'b1, lui: 1'b1, valid: 1'b1, default: 1'b0};
      end
      op_jal: begin
        ctrl.imm = imm_j;
        ctrl.wren = 1'b1;
        ctrl.jal = 1'b1;
        ctrl.valid = 1'b1;
      end
      op_jalr: begin
        ctrl.imm = imm_i;
        ctrl.wren = 1'b1;
        ctrl.rden1 = 1'b1;
        ctrl.jalr = 1'b1;
        ctrl.valid = (instr.i_fmt.funct3 == 3'b000);
      end
      op_branch: begin
        ctrl.imm = imm_b;
        ctrl.rden1 = 1'b1;
        ctrl.rden2 = 1'b1;
        ctrl.branch = 1'b1;
        ctrl.branch_ne = instr.b_fmt.funct3[0];  // beq 000, bne 001
        ctrl.valid = (instr.b_fmt.funct3[2:1] == 2'b00);
      end
      op_load: begin
        ctrl.imm = imm_i;
        ctrl.wren = 1'b1;
        ctrl.rden1 = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.load = 1'b1;
        ctrl.valid = (instr.i_fmt.funct3 == 3'b010);  // lw only
      end
      op_store: begin
        ctrl.imm = imm_s;
        ctrl.rden1 = 1'b1;
        ctrl.rden2 = 1'b1;
        ctrl.store = 1'b1;
        ctrl.valid = (instr.s_fmt.funct3 == 3'b010);
      end
      op_imm: begin
        ctrl.imm = imm_i;
        ctrl.wren = 1'b1;
        ctrl.rden1 = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.valid = (instr.i_fmt.funct3 == 3'b000);  // addi
      end
      op_reg: begin
        ctrl.wren = 1'b1;
        ctrl.rden1 = 1'b1;
        ctrl.rden2 = 1'b1;
        ctrl.valid = 1'b1;
        case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
          10'b0000000_000: ctrl.alu_op = alu_add;
          10'b0100000_000: ctrl.alu_op = alu_sub;
          10'b0000000_111: ctrl.alu_op = alu_and;
          10'b0000000_110: ctrl.alu_op = alu_or;
          10'b0000000_100: ctrl.alu_op = alu_xor;
          10'b0000000_010: ctrl.alu_op = alu_slt;
          default: ctrl.valid = 1'b0;
        endcase
      end
      op_system: begin
        if (instr.i_fmt.rs1 == 5'd0 && instr.i_fmt.rd == 5'd0 && instr.i_fmt.funct3 == 3'b000) begin
          ctrl.ecall = (instr.i_fmt.imm == 12'h000);
          ctrl.ebreak = (instr.i_fmt.imm == 12'h001);
          ctrl.valid = ctrl.ecall || ctrl.ebreak;
        end
      end
      default: ctrl.valid = 1'b0;
    endcase
    if (ctrl.waddr == 5'd0) begin
      ctrl.wren = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

module register_file
  import core_pkg::*;
(
  input wire logic clock,
  input wire logic reset,
  input wire logic [4:0] raddr1,
  input wire logic [4:0] raddr2,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2,
  input wire logic wen,
  input wire logic [4:0] waddr,
  input wire logic [xlen-1:0] wdata
);

  logic [xlen-1:0] regs [32];

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

//--- test/core_tb.sv
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clock_period = 20;
  localparam int reset_cycles = 2;
  localparam int num_tests = 5;
  localparam int test_limit = 150;  // Cycles per test
  localparam int watchdog_ns =
    (num_tests * (test_limit + reset_cycles + 1) + 10) * clock_period;
  localparam logic [31:0] done_addr = 32'h0000_03fc;

  logic clock;
  logic reset;
  logic [31:0] imem_addr, imem_data;
  logic dmem_valid, dmem_write;
  logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
  logic trap;
  logic [31:0] trap_pc;
  logic [3:0] trap_cause;

  logic [31:0] imem [1024];
  logic [31:0] dmem [1024];
  logic [31:0] prog_ptr;
  logic [15:0] lfsr_state = 16'd49109;
  int errors, start_errors, tests_run, tests_failed;
  logic [31:0] st_addr[$], st_data[$], exp_addr[$], exp_data[$];
  logic [31:0] tr_pc[$], exp_tpc[$];
  logic [3:0] tr_cause[$], exp_cause[$];
  time st_time[$], tr_time[$];

  core_top u_dut (
    .clock(clock),
    .reset(reset),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .dmem_valid(dmem_valid),
    .dmem_write(dmem_write),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .trap(trap),
    .trap_pc(trap_pc),
    .trap_cause(trap_cause)
  );

  // Both memories answer in the same cycle
  assign imem_data = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem_valid ? dmem[dmem_addr[11:2]] : '0;  // Only for a valid access

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, a test hung", watchdog_ns);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h0001_0003) ^ 32'hc35a_0000;
  endfunction

  function automatic logic [31:0] sext12(input logic [31:0] v);
    return {{20{v[11]}}, v[11:0]};
  endfunction

  function automatic logic [31:0] signed_less(input logic [31:0] x, input logic [31:0] y);
    if (x[31] != y[31]) begin
      return {31'd0, x[31]};  // The negative one is smaller
    end
    return (x < y) ? 32'd1 : 32'd0;
  endfunction

  function automatic logic [31:0] itype(input logic [31:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input logic [31:0] imm);
    return itype(imm, rs1, 3'b000, rd, 7'b0010011);
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input logic [31:0] imm);
    return itype(imm, rs1, 3'b010, rd, 7'b0000011);
  endfunction

  function automatic logic [31:0] jalr(input int rd, input int rs1, input logic [31:0] imm);
    return itype(imm, rs1, 3'b000, rd, 7'b1100111);
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input logic [31:0] imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input logic [31:0] off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] lui(input int rd, input logic [31:0] value);
    return {value[31:12], rd[4:0], 7'b0110111};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_ptr[11:2]] = word;
    prog_ptr = prog_ptr + 32'd4;
  endtask

  task automatic load_const(input int rd, input logic [31:0] value);
    emit(lui(rd, value + 32'h0000_0800));  // Rounds for the signed low part
    emit(addi(rd, rd, value));
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic expect_trap(input logic [31:0] pc, input logic [3:0] cause);
    exp_tpc.push_back(pc);
    exp_cause.push_back(cause);
  endtask

  task automatic report_mismatch(input time t, input string name,
                                 input logic [31:0] expected, input logic [31:0] actual);
    errors++;
    $display("mismatch at %0d ns: %s expected %h, actual %h", t, name, expected, actual);
  endtask

  task automatic prepare_test();
    start_errors = errors;
    prog_ptr = 32'h0;
    st_addr.delete();
    st_data.delete();
    st_time.delete();
    exp_addr.delete();
    exp_data.delete();
    tr_pc.delete();
    tr_cause.delete();
    tr_time.delete();
    exp_tpc.delete();
    exp_cause.delete();
    for (int i = 0; i < 1024; i++) begin
      imem[i] = 32'h0000_0013;
      dmem[i] = fill_word(i * 4);
    end
  endtask

  task automatic run_program(input int limit);
    int cycles;
    logic done;
    @(negedge clock);
    reset = 1'b0;
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b1;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < limit) begin
      @(negedge clock);
      cycles++;
      if (trap === 1'b1) begin
        tr_pc.push_back(trap_pc);
        tr_cause.push_back(trap_cause);
        tr_time.push_back($time);
      end
      if (dmem_write === 1'b1 && dmem_valid !== 1'b1) begin
        errors++;
        $display("dmem_write rose without dmem_valid at %0d ns", $time);
      end
      if (dmem_write === 1'b1) begin
        if (dmem_addr[1:0] != 2'b00) begin
          errors++;
          $display("misaligned store to %h reached dmem_write at %0d ns", dmem_addr, $time);
        end else if (dmem_addr == done_addr) begin
          done = 1'b1;
        end else begin
          dmem[dmem_addr[11:2]] = dmem_wdata;  // Lands before the next load
          st_addr.push_back(dmem_addr);
          st_data.push_back(dmem_wdata);
          st_time.push_back($time);
        end
      end
    end
    if (!done) begin
      errors++;
      $display("program never stored to the done address within %0d cycles", limit);
    end
  endtask

  task automatic score_test(input string name);
    int n;
    if (st_addr.size() != exp_addr.size()) begin
      errors++;
      $display("%s: expected %0d stores, saw %0d", name, exp_addr.size(), st_addr.size());
    end
    n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      if (st_addr[i] !== exp_addr[i]) begin
        report_mismatch(st_time[i], "dmem_addr", exp_addr[i], st_addr[i]);
      end
      if (st_data[i] !== exp_data[i]) begin
        report_mismatch(st_time[i], "dmem_wdata", exp_data[i], st_data[i]);
      end
    end
    if (tr_pc.size() != exp_tpc.size()) begin
      errors++;
      $display("%s: expected %0d traps, saw %0d", name, exp_tpc.size(), tr_pc.size());
    end
    n = (tr_pc.size() < exp_tpc.size()) ? tr_pc.size() : exp_tpc.size();
    for (int i = 0; i < n; i++) begin
      if (tr_pc[i] !== exp_tpc[i]) begin
        report_mismatch(tr_time[i], "trap_pc", exp_tpc[i], tr_pc[i]);
      end
      if (tr_cause[i] !== exp_cause[i]) begin
        report_mismatch(tr_time[i], "trap_cause", {28'd0, exp_cause[i]}, {28'd0, tr_cause[i]});
      end
    end
    tests_run++;
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic alu_ops();
    logic [31:0] a, b, c, imm;
    prepare_test();
    a = random_bits(32);
    b = random_bits(32);
    c = a ^ 32'h8000_0000;  // Opposite sign, so slt must be signed
    imm = random_bits(12);
    load_const(1, a);
    load_const(2, b);
    load_const(3, c);
    emit(lui(4, b));
    emit(addi(5, 1, imm));
    emit(alu_rr(7'h00, 3'b000, 6, 1, 2));
    emit(alu_rr(7'h20, 3'b000, 7, 1, 2));
    emit(alu_rr(7'h00, 3'b111, 8, 1, 2));
    emit(alu_rr(7'h00, 3'b110, 9, 1, 2));
    emit(alu_rr(7'h00, 3'b100, 10, 1, 2));
    emit(alu_rr(7'h00, 3'b010, 11, 1, 2));
    emit(alu_rr(7'h00, 3'b010, 12, 1, 3));
    emit(alu_rr(7'h00, 3'b010, 13, 3, 1));
    for (int r = 4; r <= 13; r++) begin
      emit(sw(r, 0, 32'h200 + (r - 4) * 4));
    end
    emit(sw(0, 0, done_addr));
    expect_store(32'h200, {b[31:12], 12'h000});
    expect_store(32'h204, a + sext12(imm));
    expect_store(32'h208, a + b);
    expect_store(32'h20c, a - b);
    expect_store(32'h210, a & b);
    expect_store(32'h214, a | b);
    expect_store(32'h218, a ^ b);
    expect_store(32'h21c, signed_less(a, b));
    expect_store(32'h220, signed_less(a, c));
    expect_store(32'h224, signed_less(c, a));
    run_program(test_limit);
    score_test("alu");
  endtask

  task automatic forwarding_chain();
    logic [31:0] a, i1, i2, v2, v3, v4, v6;
    prepare_test();
    a = random_bits(32);
    i1 = random_bits(12);
    i2 = random_bits(12);
    load_const(1, a);
    emit(addi(2, 1, i1));
    emit(alu_rr(7'h00, 3'b000, 3, 2, 1));
    emit(alu_rr(7'h20, 3'b000, 4, 3, 2));
    emit(sw(4, 0, 32'h200));
    emit(lw(5, 0, 32'h200));
    emit(addi(6, 5, i2));  // Load result used at once
    emit(sw(6, 0, 32'h204));
    emit(alu_rr(7'h00, 3'b100, 7, 6, 4));
    emit(sw(7, 0, 32'h208));
    emit(sw(0, 0, done_addr));
    v2 = a + sext12(i1);
    v3 = v2 + a;
    v4 = v3 - v2;
    v6 = v4 + sext12(i2);
    expect_store(32'h200, v4);
    expect_store(32'h204, v6);
    expect_store(32'h208, v6 ^ v4);
    run_program(test_limit);
    score_test("forwarding");
  endtask

  task automatic store_load();
    logic [31:0] d;
    prepare_test();
    d = random_bits(32);
    load_const(1, d);
    load_const(2, 32'h300);
    emit(sw(1, 2, 32'd8));
    emit(lw(3, 2, 32'd8));
    emit(sw(3, 0, 32'h244));
    emit(lw(4, 0, 32'h280));
    emit(sw(4, 0, 32'h248));
    emit(sw(0, 0, done_addr));
    expect_store(32'h308, d);
    expect_store(32'h244, d);
    expect_store(32'h248, fill_word(32'h280));
    run_program(test_limit);
    score_test("memory");
  endtask

  task automatic branches_and_jumps();
    logic [31:0] jal_pc, jalr_pc;
    prepare_test();
    emit(addi(1, 0, 32'd5));
    emit(addi(2, 0, 32'd5));
    emit(branch(3'b000, 1, 2, 32'd8));  // beq taken
    emit(sw(1, 0, 32'h2f0));
    emit(branch(3'b001, 1, 2, 32'd8));  // bne falls through
    emit(addi(3, 0, 32'd7));
    emit(sw(3, 0, 32'h200));
    emit(branch(3'b000, 1, 3, 32'd8));
    emit(branch(3'b001, 1, 3, 32'd8));
    emit(sw(1, 0, 32'h2f4));
    jal_pc = prog_ptr;
    emit(jal(4, 32'd12));
    emit(sw(1, 0, 32'h2f8));
    emit(sw(1, 0, 32'h2fc));
    emit(sw(4, 0, 32'h204));
    emit(addi(5, 0, prog_ptr + 32'd17));  // Odd sum, bit 0 dropped
    jalr_pc = prog_ptr;
    emit(jalr(6, 5, 32'd4));
    emit(sw(1, 0, 32'h2f0));
    emit(sw(1, 0, 32'h2f4));
    emit(sw(1, 0, 32'h2f8));
    emit(sw(6, 0, 32'h208));
    emit(sw(0, 0, done_addr));
    expect_store(32'h200, 32'd7);
    expect_store(32'h204, jal_pc + 32'd4);
    expect_store(32'h208, jalr_pc + 32'd4);
    run_program(test_limit);
    score_test("control");
  endtask

  task automatic exceptions();
    logic [31:0] faults [5];
    logic [3:0] causes [5];
    faults[0] = 32'hffff_ffff;
    faults[1] = 32'h0000_0073;
    faults[2] = 32'h0010_0073;
    faults[3] = lw(7, 0, 32'h201);
    faults[4] = sw(1, 0, 32'h2c2);
    causes[0] = 4'd2;
    causes[1] = 4'd11;
    causes[2] = 4'd3;
    causes[3] = 4'd4;
    causes[4] = 4'd6;
    prepare_test();
    for (int k = 0; k < 5; k++) begin
      emit(addi(11, 0, prog_ptr + 32'd12));  // Resume past the wrong-path store
      expect_trap(prog_ptr, causes[k]);
      emit(faults[k]);
      emit(sw(1, 0, 32'h2c0));
      expect_store(32'h280, k + 1);
    end
    emit(sw(0, 0, done_addr));
    prog_ptr = 32'h100;
    emit(addi(10, 10, 32'd1));
    emit(sw(10, 0, 32'h280));
    emit(jalr(0, 11, 32'd0));
    run_program(test_limit);
    score_test("exceptions");
  endtask

  initial begin
    reset = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    alu_ops();
    forwarding_chain();
    store_load();
    branches_and_jumps();
    exceptions();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/core_pkg.sv
hw/fetch_stage.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/core_top.sv
test/core_tb.sv
